// ==== hw/npc_axi_pkg.sv ====
package npc_axi_pkg;

  // bus geometry
  localparam int unsigned MEM_WORDS  = 1024;
  localparam int unsigned WORD_BYTES = 8;
  localparam int unsigned WORD_OFF   = $clog2(WORD_BYTES);  // byte offset bits in a beat
  localparam int unsigned MEM_IDX_W  = $clog2(MEM_WORDS);

  typedef logic [31:0]          addr_t;
  typedef logic [63:0]          data_t;
  typedef logic [7:0]           strb_t;
  typedef logic [7:0]           len_t;     // beats minus one
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           burst_t;
  typedef logic [1:0]           resp_t;
  typedef logic [MEM_IDX_W-1:0] mem_idx_t; // word index into the sram

  // only 8-byte incrementing bursts on this bus
  localparam size_t  SIZE_8B    = 3'd3;
  localparam burst_t BURST_INCR = 2'b01;
  localparam resp_t  RESP_OKAY  = 2'b00;

endpackage

// ==== hw/npc_core_pkg.sv ====
package npc_core_pkg;

  typedef logic [63:0] pc_t;
  typedef logic [31:0] inst_t;

  localparam pc_t RESET_PC = 64'h0;

  // fetch queue sizing, depth kept a power of two so pointers wrap by themselves
  localparam int unsigned FQ_DEPTH = 4;
  localparam int unsigned FQ_PTR_W = $clog2(FQ_DEPTH);

  typedef logic [FQ_PTR_W-1:0] fq_ptr_t;
  typedef logic [FQ_PTR_W:0]   fq_cnt_t;  // one extra bit to hold FQ_DEPTH

endpackage

// ==== hw/npc_ifu.sv ====
`timescale 1ns/1ps

module npc_ifu (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                pc_update,
  input  npc_core_pkg::pc_t   dnpc,
  output logic                ar_valid,
  output npc_axi_pkg::addr_t  ar_addr,
  output npc_axi_pkg::len_t   ar_len,
  input  logic                ar_ready,
  input  logic                r_valid,
  input  npc_axi_pkg::data_t  r_data,
  input  logic                r_last,
  output logic                r_ready,
  output logic                push,
  output npc_core_pkg::pc_t   push_pc,
  output npc_core_pkg::inst_t push_inst,
  input  logic                full
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_SPLIT} state_e;

  state_e             state_q;
  npc_core_pkg::pc_t  pc_q;      // pc of the next instruction to push
  npc_core_pkg::pc_t  next_pc;
  npc_axi_pkg::addr_t addr_q;    // word address of the read in progress
  npc_axi_pkg::addr_t next_addr;
  npc_axi_pkg::data_t word_q;    // hold register
  logic               stale_q;   // in-flight read belongs to an old stream

  assign ar_valid = (state_q == S_REQ);
  assign ar_addr  = addr_q;
  assign ar_len   = '0;          // single beat per read
  assign r_ready  = (state_q == S_WAIT); // hold register empty

  assign push      = (state_q == S_SPLIT) && !full;
  assign push_pc   = pc_q;
  assign push_inst = pc_q[2] ? word_q[63:32] : word_q[31:0]; // low half first

  // redirect wins over sequential advance
  assign next_pc   = pc_update ? dnpc : (push ? pc_q + 64'd4 : pc_q);
  assign next_addr = npc_axi_pkg::addr_t'(next_pc) &
                     ~npc_axi_pkg::addr_t'(npc_axi_pkg::WORD_BYTES - 1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_IDLE;
      pc_q    <= npc_core_pkg::RESET_PC;
      addr_q  <= '0;
      stale_q <= 1'b0;
    end else begin
      pc_q <= next_pc;
      case (state_q)
        S_IDLE: begin
          state_q <= S_REQ;
          addr_q  <= next_addr;
        end
        S_REQ: begin
          // address already offered, so a redirect only marks it stale
          stale_q <= stale_q | pc_update;
          if (ar_ready) state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (r_valid && r_last) begin
            if (stale_q || pc_update) begin
              state_q <= S_REQ;  // drop the old word, refetch
              addr_q  <= next_addr;
              stale_q <= 1'b0;
            end else begin
              state_q <= S_SPLIT;
            end
          end else begin
            stale_q <= stale_q | pc_update;
          end
        end
        S_SPLIT: begin
          if (pc_update || (push && pc_q[2])) begin // redirect or upper half done
            state_q <= S_REQ;
            addr_q  <= next_addr;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (r_valid && r_ready) word_q <= r_data;
  end

  // stalled on a full queue, the offered instruction holds
  a_hold_on_full: assert property (@(posedge clk) disable iff (!arst_n)
    state_q == S_SPLIT && full && !pc_update |=> $stable(push_pc) && $stable(push_inst));

  // request must hold its address until the arbiter takes it
  a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

endmodule

// ==== hw/npc_fetch_queue.sv ====
`timescale 1ns/1ps

module npc_fetch_queue (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                flush,
  input  logic                push,
  input  npc_core_pkg::pc_t   push_pc,
  input  npc_core_pkg::inst_t push_inst,
  output logic                full,
  output logic                inst_valid,
  output npc_core_pkg::pc_t   inst_pc,
  output npc_core_pkg::inst_t inst,
  input  logic                inst_ready
);

  npc_core_pkg::pc_t    pc_mem   [npc_core_pkg::FQ_DEPTH];
  npc_core_pkg::inst_t  inst_mem [npc_core_pkg::FQ_DEPTH];
  npc_core_pkg::fq_ptr_t rd_ptr_q, wr_ptr_q;
  npc_core_pkg::fq_cnt_t count_q;
  logic                  do_push, do_pop;

  assign full       = (count_q == npc_core_pkg::fq_cnt_t'(npc_core_pkg::FQ_DEPTH));
  assign inst_valid = (count_q != '0);
  assign inst_pc    = pc_mem[rd_ptr_q];
  assign inst       = inst_mem[rd_ptr_q];

  assign do_push = push && !full && !flush; // push in a flush cycle is dropped
  assign do_pop  = inst_valid && inst_ready && !flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      pc_mem[wr_ptr_q]   <= push_pc;
      inst_mem[wr_ptr_q] <= push_inst;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
    count_q <= npc_core_pkg::fq_cnt_t'(npc_core_pkg::FQ_DEPTH));

endmodule

// ==== hw/npc_arbiter.sv ====
`timescale 1ns/1ps

module npc_arbiter (
  input  logic                 clk,
  input  logic                 arst_n,
  // fetch master, read only
  input  logic                 ifu_arvalid,
  input  npc_axi_pkg::addr_t   ifu_araddr,
  input  npc_axi_pkg::len_t    ifu_arlen,
  output logic                 ifu_arready,
  output logic                 ifu_rvalid,
  output npc_axi_pkg::data_t   ifu_rdata,
  output logic                 ifu_rlast,
  input  logic                 ifu_rready,
  // data master
  input  logic                 mem_arvalid,
  input  npc_axi_pkg::addr_t   mem_araddr,
  input  npc_axi_pkg::len_t    mem_arlen,
  output logic                 mem_arready,
  output logic                 mem_rvalid,
  output npc_axi_pkg::data_t   mem_rdata,
  output logic                 mem_rlast,
  input  logic                 mem_rready,
  input  logic                 mem_awvalid,
  input  npc_axi_pkg::addr_t   mem_awaddr,
  input  npc_axi_pkg::len_t    mem_awlen,
  output logic                 mem_awready,
  input  logic                 mem_wvalid,
  input  npc_axi_pkg::data_t   mem_wdata,
  input  npc_axi_pkg::strb_t   mem_wstrb,
  input  logic                 mem_wlast,
  output logic                 mem_wready,
  output logic                 mem_bvalid,
  output npc_axi_pkg::resp_t   mem_bresp,
  input  logic                 mem_bready,
  // slave side
  output logic                 s_arvalid,
  output npc_axi_pkg::addr_t   s_araddr,
  output npc_axi_pkg::len_t    s_arlen,
  output npc_axi_pkg::size_t   s_arsize,
  output npc_axi_pkg::burst_t  s_arburst,
  input  logic                 s_arready,
  input  logic                 s_rvalid,
  input  npc_axi_pkg::data_t   s_rdata,
  input  logic                 s_rlast,
  output logic                 s_rready,
  output logic                 s_awvalid,
  output npc_axi_pkg::addr_t   s_awaddr,
  output npc_axi_pkg::len_t    s_awlen,
  input  logic                 s_awready,
  output logic                 s_wvalid,
  output npc_axi_pkg::data_t   s_wdata,
  output npc_axi_pkg::strb_t   s_wstrb,
  output logic                 s_wlast,
  input  logic                 s_wready,
  input  logic                 s_bvalid,
  input  npc_axi_pkg::resp_t   s_bresp,
  output logic                 s_bready
);

  typedef enum logic [1:0] {OWN_NONE, OWN_IFU, OWN_MEM} owner_e;

  owner_e owner_q;
  logic   gnt_mem, gnt_ifu;

  // data side first, fetch only when data is quiet
  assign gnt_mem = (owner_q == OWN_NONE) && mem_arvalid;
  assign gnt_ifu = (owner_q == OWN_NONE) && !mem_arvalid && ifu_arvalid;

  assign s_arvalid   = gnt_mem || gnt_ifu;
  assign s_araddr    = gnt_mem ? mem_araddr : ifu_araddr;
  assign s_arlen     = gnt_mem ? mem_arlen : ifu_arlen;
  assign s_arsize    = npc_axi_pkg::SIZE_8B;
  assign s_arburst   = npc_axi_pkg::BURST_INCR;
  assign mem_arready = gnt_mem && s_arready;
  assign ifu_arready = gnt_ifu && s_arready;

  // R goes back to whoever holds the channel
  assign ifu_rvalid = s_rvalid && (owner_q == OWN_IFU);
  assign mem_rvalid = s_rvalid && (owner_q == OWN_MEM);
  assign ifu_rdata  = s_rdata;
  assign mem_rdata  = s_rdata;
  assign ifu_rlast  = s_rlast;
  assign mem_rlast  = s_rlast;
  assign s_rready   = (owner_q == OWN_MEM) ? mem_rready :
                      (owner_q == OWN_IFU) ? ifu_rready : 1'b0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner_q <= OWN_NONE;
    end else if (owner_q == OWN_NONE) begin
      if (s_arvalid && s_arready) owner_q <= gnt_mem ? OWN_MEM : OWN_IFU;
    end else if (s_rvalid && s_rready && s_rlast) begin
      owner_q <= OWN_NONE;  // released after the last beat
    end
  end

  // write side has a single user
  assign s_awvalid   = mem_awvalid;
  assign s_awaddr    = mem_awaddr;
  assign s_awlen     = mem_awlen;
  assign mem_awready = s_awready;
  assign s_wvalid    = mem_wvalid;
  assign s_wdata     = mem_wdata;
  assign s_wstrb     = mem_wstrb;
  assign s_wlast     = mem_wlast;
  assign mem_wready  = s_wready;
  assign mem_bvalid  = s_bvalid;
  assign mem_bresp   = s_bresp;
  assign s_bready    = mem_bready;

  // slave must never answer a read nobody was granted
  a_r_owned: assert property (@(posedge clk) disable iff (!arst_n)
    s_rvalid |-> owner_q != OWN_NONE);

endmodule

// ==== hw/npc_sram.sv ====
`timescale 1ns/1ps

module npc_sram (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                arvalid,
  input  npc_axi_pkg::addr_t  araddr,
  input  npc_axi_pkg::len_t   arlen,
  output logic                arready,
  output logic                rvalid,
  output npc_axi_pkg::data_t  rdata,
  output logic                rlast,
  input  logic                rready,
  input  logic                awvalid,
  input  npc_axi_pkg::addr_t  awaddr,
  input  npc_axi_pkg::len_t   awlen,
  output logic                awready,
  input  logic                wvalid,
  input  npc_axi_pkg::data_t  wdata,
  input  npc_axi_pkg::strb_t  wstrb,
  input  logic                wlast,
  output logic                wready,
  output logic                bvalid,
  output npc_axi_pkg::resp_t  bresp,
  input  logic                bready
);

  typedef enum logic {R_IDLE, R_DATA} rd_state_e;
  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_e;

  npc_axi_pkg::data_t    mem_q [npc_axi_pkg::MEM_WORDS];
  rd_state_e             rd_state_q;
  wr_state_e             wr_state_q;
  npc_axi_pkg::mem_idx_t raddr_q, waddr_q;
  npc_axi_pkg::len_t     rlen_q, rcnt_q;
  npc_axi_pkg::len_t     wlen_q, wcnt_q;

  // read side
  assign arready = (rd_state_q == R_IDLE);
  assign rvalid  = (rd_state_q == R_DATA);
  assign rdata   = mem_q[raddr_q];
  assign rlast   = rvalid && (rcnt_q == rlen_q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state_q <= R_IDLE;
      raddr_q    <= '0;
      rlen_q     <= '0;
      rcnt_q     <= '0;
    end else begin
      case (rd_state_q)
        R_IDLE: if (arvalid) begin
          raddr_q    <= araddr[npc_axi_pkg::WORD_OFF +: npc_axi_pkg::MEM_IDX_W]; // wraps
          rlen_q     <= arlen;
          rcnt_q     <= '0;
          rd_state_q <= R_DATA;
        end
        R_DATA: if (rready) begin
          if (rlast) begin
            rd_state_q <= R_IDLE;
          end else begin
            raddr_q <= raddr_q + 1'b1;
            rcnt_q  <= rcnt_q + 1'b1;
          end
        end
        default: rd_state_q <= R_IDLE;
      endcase
    end
  end

  // write side
  assign awready = (wr_state_q == W_IDLE);
  assign wready  = (wr_state_q == W_DATA);
  assign bvalid  = (wr_state_q == W_RESP);
  assign bresp   = npc_axi_pkg::RESP_OKAY;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state_q <= W_IDLE;
      waddr_q    <= '0;
      wlen_q     <= '0;
      wcnt_q     <= '0;
    end else begin
      case (wr_state_q)
        W_IDLE: if (awvalid) begin
          waddr_q    <= awaddr[npc_axi_pkg::WORD_OFF +: npc_axi_pkg::MEM_IDX_W];
          wlen_q     <= awlen;
          wcnt_q     <= '0;
          wr_state_q <= W_DATA;
        end
        W_DATA: if (wvalid) begin
          waddr_q <= waddr_q + 1'b1;
          wcnt_q  <= wcnt_q + 1'b1;
          if (wlast) wr_state_q <= W_RESP; // response the cycle after
        end
        W_RESP: if (bready) wr_state_q <= W_IDLE;
        default: wr_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wvalid && wready) begin
      for (int b = 0; b < npc_axi_pkg::WORD_BYTES; b++) begin
        if (wstrb[b]) mem_q[waddr_q][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // master's wlast has to agree with the awlen it announced
  a_wlast_count: assert property (@(posedge clk) disable iff (!arst_n)
    wvalid && wready |-> (wlast == (wcnt_q == wlen_q)));

endmodule

// ==== hw/npc_fetch_top.sv ====
`timescale 1ns/1ps

module npc_fetch_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                pc_update,
  input  npc_core_pkg::pc_t   dnpc,
  output logic                inst_valid,
  output npc_core_pkg::pc_t   inst_pc,
  output npc_core_pkg::inst_t inst,
  input  logic                inst_ready,
  input  logic                mem_arvalid,
  input  npc_axi_pkg::addr_t  mem_araddr,
  input  npc_axi_pkg::len_t   mem_arlen,
  output logic                mem_arready,
  output logic                mem_rvalid,
  output npc_axi_pkg::data_t  mem_rdata,
  output logic                mem_rlast,
  input  logic                mem_rready,
  input  logic                mem_awvalid,
  input  npc_axi_pkg::addr_t  mem_awaddr,
  input  npc_axi_pkg::len_t   mem_awlen,
  output logic                mem_awready,
  input  logic                mem_wvalid,
  input  npc_axi_pkg::data_t  mem_wdata,
  input  npc_axi_pkg::strb_t  mem_wstrb,
  input  logic                mem_wlast,
  output logic                mem_wready,
  output logic                mem_bvalid,
  output npc_axi_pkg::resp_t  mem_bresp,
  input  logic                mem_bready
);

  // fetch unit to queue
  logic                push, full;
  npc_core_pkg::pc_t   push_pc;
  npc_core_pkg::inst_t push_inst;

  // fetch master read channel
  logic               ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rlast, ifu_rready;
  npc_axi_pkg::addr_t ifu_araddr;
  npc_axi_pkg::len_t  ifu_arlen;
  npc_axi_pkg::data_t ifu_rdata;

  // arbiter to sram
  logic               s_arvalid, s_arready, s_rvalid, s_rlast, s_rready;
  logic               s_awvalid, s_awready, s_wvalid, s_wlast, s_wready, s_bvalid, s_bready;
  npc_axi_pkg::addr_t s_araddr, s_awaddr;
  npc_axi_pkg::len_t  s_arlen, s_awlen;
  npc_axi_pkg::data_t s_rdata, s_wdata;
  npc_axi_pkg::strb_t s_wstrb;
  npc_axi_pkg::resp_t s_bresp;

  npc_ifu npc_ifu_i (
    .clk(clk), .arst_n(arst_n), .pc_update(pc_update), .dnpc(dnpc),
    .ar_valid(ifu_arvalid), .ar_addr(ifu_araddr), .ar_len(ifu_arlen), .ar_ready(ifu_arready),
    .r_valid(ifu_rvalid), .r_data(ifu_rdata), .r_last(ifu_rlast), .r_ready(ifu_rready),
    .push(push), .push_pc(push_pc), .push_inst(push_inst), .full(full)
  );

  npc_fetch_queue npc_fetch_queue_i (
    .clk(clk), .arst_n(arst_n), .flush(pc_update),
    .push(push), .push_pc(push_pc), .push_inst(push_inst), .full(full),
    .inst_valid(inst_valid), .inst_pc(inst_pc), .inst(inst), .inst_ready(inst_ready)
  );

  // sram only does 8-byte INCR, so size and burst are left open
  npc_arbiter npc_arbiter_i (
    .clk(clk), .arst_n(arst_n),
    .ifu_arvalid(ifu_arvalid), .ifu_araddr(ifu_araddr), .ifu_arlen(ifu_arlen),
    .ifu_arready(ifu_arready), .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata),
    .ifu_rlast(ifu_rlast), .ifu_rready(ifu_rready),
    .mem_arvalid(mem_arvalid), .mem_araddr(mem_araddr), .mem_arlen(mem_arlen),
    .mem_arready(mem_arready), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .mem_rlast(mem_rlast), .mem_rready(mem_rready),
    .mem_awvalid(mem_awvalid), .mem_awaddr(mem_awaddr), .mem_awlen(mem_awlen),
    .mem_awready(mem_awready), .mem_wvalid(mem_wvalid), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_wlast(mem_wlast), .mem_wready(mem_wready),
    .mem_bvalid(mem_bvalid), .mem_bresp(mem_bresp), .mem_bready(mem_bready),
    .s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_arlen(s_arlen),
    .s_arsize(), .s_arburst(), .s_arready(s_arready),
    .s_rvalid(s_rvalid), .s_rdata(s_rdata), .s_rlast(s_rlast), .s_rready(s_rready),
    .s_awvalid(s_awvalid), .s_awaddr(s_awaddr), .s_awlen(s_awlen), .s_awready(s_awready),
    .s_wvalid(s_wvalid), .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wlast(s_wlast),
    .s_wready(s_wready), .s_bvalid(s_bvalid), .s_bresp(s_bresp), .s_bready(s_bready)
  );

  npc_sram npc_sram_i (
    .clk(clk), .arst_n(arst_n),
    .arvalid(s_arvalid), .araddr(s_araddr), .arlen(s_arlen), .arready(s_arready),
    .rvalid(s_rvalid), .rdata(s_rdata), .rlast(s_rlast), .rready(s_rready),
    .awvalid(s_awvalid), .awaddr(s_awaddr), .awlen(s_awlen), .awready(s_awready),
    .wvalid(s_wvalid), .wdata(s_wdata), .wstrb(s_wstrb), .wlast(s_wlast),
    .wready(s_wready), .bvalid(s_bvalid), .bresp(s_bresp), .bready(s_bready)
  );

endmodule

// ==== test/tb_npc_model.svh ====
`ifndef TB_NPC_MODEL_SVH
`define TB_NPC_MODEL_SVH

// mirror of the sram, follows every data-port write
npc_axi_pkg::data_t  model_mem [npc_axi_pkg::MEM_WORDS];

// what decode should see after the last redirect, oldest first
npc_core_pkg::pc_t   exp_pc_q   [$];
npc_core_pkg::inst_t exp_inst_q [$];

localparam int EXP_LEN = 256;  // well past any single run of fetch

task automatic model_write(input int idx, input npc_axi_pkg::data_t d,
                           input npc_axi_pkg::strb_t s);
  for (int b = 0; b < npc_axi_pkg::WORD_BYTES; b++) begin
    if (s[b]) model_mem[idx][8*b +: 8] = d[8*b +: 8];  // byte lanes by strobe
  end
endtask

function automatic npc_core_pkg::inst_t model_inst(input npc_core_pkg::pc_t pc);
  npc_axi_pkg::data_t w;
  w = model_mem[npc_axi_pkg::addr_t'(pc >> 3) % npc_axi_pkg::MEM_WORDS]; // 8-byte words
  return pc[2] ? w[63:32] : w[31:0];  // upper half sits at pc+4
endfunction

task automatic build_expected(input npc_core_pkg::pc_t start);
  npc_core_pkg::pc_t pc;
  exp_pc_q.delete();
  exp_inst_q.delete();
  pc = start;
  for (int i = 0; i < EXP_LEN; i++) begin
    exp_pc_q.push_back(pc);
    exp_inst_q.push_back(model_inst(pc));
    pc = pc + 64'd4;
  end
endtask

`endif

// ==== test/tb_npc_fetch.sv ====
`timescale 1ns/1ps

module tb_npc_fetch;

  localparam int TIMEOUT = 100;  // cycles allowed per handshake

  logic                clk;
  logic                arst_n;
  logic                pc_update;
  npc_core_pkg::pc_t   dnpc;
  logic                inst_valid;
  npc_core_pkg::pc_t   inst_pc;
  npc_core_pkg::inst_t inst;
  logic                inst_ready;
  logic                mem_arvalid, mem_arready, mem_rvalid, mem_rlast, mem_rready;
  logic                mem_awvalid, mem_awready, mem_wvalid, mem_wlast, mem_wready;
  logic                mem_bvalid, mem_bready;
  npc_axi_pkg::addr_t  mem_araddr, mem_awaddr;
  npc_axi_pkg::len_t   mem_arlen, mem_awlen;
  npc_axi_pkg::data_t  mem_rdata, mem_wdata;
  npc_axi_pkg::strb_t  mem_wstrb;
  npc_axi_pkg::resp_t  mem_bresp;

  int seed;
  int mismatches = 0;
  int timeouts   = 0;
  int consumed   = 0;  // instructions taken by decode

  `include "tb_npc_model.svh"

  npc_fetch_top npc_fetch_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int unsigned rnd(input int unsigned range);
    return $unsigned($random(seed)) % range;
  endfunction

  task automatic check_inst(input string name, input npc_core_pkg::inst_t got,
                            input npc_core_pkg::inst_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_pc(input string name, input npc_core_pkg::pc_t got,
                          input npc_core_pkg::pc_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input npc_axi_pkg::data_t got,
                            input npc_axi_pkg::data_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input npc_axi_pkg::resp_t got,
                            input npc_axi_pkg::resp_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("%0t: %s did not complete within the allowed cycles", $time, what);
  endtask

  // decode side, transfer happens at the next rising edge
  always @(negedge clk) begin
    if (arst_n && inst_valid && inst_ready && !pc_update) begin
      if (exp_pc_q.size() == 0) begin
        mismatches++;
        $display("%0t: instruction at pc %h arrived past the expected stream", $time, inst_pc);
      end else begin
        check_pc("inst_pc", inst_pc, exp_pc_q.pop_front());
        check_inst("inst", inst, exp_inst_q.pop_front());
      end
      consumed++;
    end
  end

  task automatic redirect(input npc_core_pkg::pc_t target);
    @(posedge clk);
    #1;
    pc_update  = 1'b1;
    dnpc       = target;
    inst_ready = 1'b0;
    build_expected(target);
    @(posedge clk);
    #1;
    pc_update = 1'b0;
  endtask

  // accept n instructions, randomly stalling when bp is set
  task automatic run_fetch(input int n, input bit bp);
    int target;
    int t;
    target = consumed + n;
    t = 0;
    @(posedge clk);
    #1;
    while (consumed < target && t < 40 * n + TIMEOUT) begin
      if (bp) inst_ready = (rnd(2) == 0);
      else inst_ready = 1'b1;
      @(posedge clk);
      #1;
      t++;
    end
    inst_ready = 1'b0;
    if (consumed < target) report_timeout("instruction stream");
  endtask

  task automatic mem_write_burst(input int idx, input int beats, input bit rand_strb);
    npc_axi_pkg::data_t d;
    npc_axi_pkg::strb_t s;
    int t;
    bit ok;
    @(posedge clk);
    #1;
    mem_awvalid = 1'b1;
    mem_awaddr  = npc_axi_pkg::addr_t'(idx * npc_axi_pkg::WORD_BYTES);
    mem_awlen   = npc_axi_pkg::len_t'(beats - 1);
    t = 0;
    @(negedge clk);
    while (!mem_awready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    ok = mem_awready;
    @(posedge clk);
    #1;
    mem_awvalid = 1'b0;
    if (!ok) begin
      report_timeout("write address handshake");
      return;
    end
    for (int b = 0; b < beats && ok; b++) begin
      d = {$random(seed), $random(seed)};
      s = rand_strb ? npc_axi_pkg::strb_t'(rnd(256)) : '1;
      mem_wvalid = 1'b1;
      mem_wdata  = d;
      mem_wstrb  = s;
      mem_wlast  = (b == beats - 1);
      t = 0;
      @(negedge clk);
      while (!mem_wready && t < TIMEOUT) begin
        @(negedge clk);
        t++;
      end
      ok = mem_wready;
      if (ok) model_write((idx + b) % npc_axi_pkg::MEM_WORDS, d, s);
      @(posedge clk);
      #1;
    end
    mem_wvalid = 1'b0;
    mem_wlast  = 1'b0;
    if (!ok) begin
      report_timeout("write data beat");
      return;
    end
    mem_bready = 1'b1;
    t = 0;
    @(negedge clk);
    while (!mem_bvalid && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    ok = mem_bvalid;
    if (ok) check_resp("mem_bresp", mem_bresp, npc_axi_pkg::resp_t'(2'b00)); // okay
    @(posedge clk);
    #1;
    mem_bready = 1'b0;
    if (!ok) report_timeout("write response");
  endtask

  task automatic mem_read_burst(input int idx, input int beats);
    int t;
    bit ok;
    @(posedge clk);
    #1;
    mem_arvalid = 1'b1;
    mem_araddr  = npc_axi_pkg::addr_t'(idx * npc_axi_pkg::WORD_BYTES);
    mem_arlen   = npc_axi_pkg::len_t'(beats - 1);
    t = 0;
    @(negedge clk);
    while (!mem_arready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    ok = mem_arready;
    @(posedge clk);
    #1;
    mem_arvalid = 1'b0;
    if (!ok) begin
      report_timeout("read address handshake");
      return;
    end
    mem_rready = 1'b1;
    for (int b = 0; b < beats && ok; b++) begin
      t = 0;
      @(negedge clk);
      while (!mem_rvalid && t < TIMEOUT) begin
        @(negedge clk);
        t++;
      end
      ok = mem_rvalid;
      if (ok) begin
        check_data("mem_rdata", mem_rdata, model_mem[(idx + b) % npc_axi_pkg::MEM_WORDS]);
        check_bit("mem_rlast", mem_rlast, b == beats - 1);
      end
      @(posedge clk);
    end
    #1;
    mem_rready = 1'b0;
    if (!ok) report_timeout("read data beat");
  endtask

  // mixed reads anywhere and writes kept above the code area
  task automatic data_traffic(input int n);
    int beats;
    for (int i = 0; i < n; i++) begin
      beats = 1 + int'(rnd(8));
      if (rnd(2) == 0) mem_write_burst(512 + int'(rnd(504)), beats, 1'b1);
      else mem_read_burst(int'(rnd(npc_axi_pkg::MEM_WORDS)), beats);
      repeat (rnd(4)) @(posedge clk);
    end
  endtask

  initial begin
    int idx;
    int beats;
    seed        = 32'h4a5d;
    arst_n      = 1'b0;
    pc_update   = 1'b0;
    dnpc        = '0;
    inst_ready  = 1'b0;
    mem_arvalid = 1'b0;
    mem_araddr  = '0;
    mem_arlen   = '0;
    mem_rready  = 1'b0;
    mem_awvalid = 1'b0;
    mem_awaddr  = '0;
    mem_awlen   = '0;
    mem_wvalid  = 1'b0;
    mem_wdata   = '0;
    mem_wstrb   = '0;
    mem_wlast   = 1'b0;
    mem_bready  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // whole memory loaded, then straight-line fetch from 0
    for (int w = 0; w < npc_axi_pkg::MEM_WORDS; w += 8) mem_write_burst(w, 8, 1'b0);
    redirect('0);
    run_fetch(200, 1'b0);

    // redirects, some to upper halves, some back to back
    for (int i = 0; i < 30; i++) begin
      redirect(npc_core_pkg::pc_t'(rnd(400) * 8 + rnd(2) * 4));
      run_fetch(int'(rnd(11)), 1'b1);
      repeat (rnd(3)) @(posedge clk);
    end

    for (int i = 0; i < 20; i++) begin
      idx   = int'(rnd(npc_axi_pkg::MEM_WORDS));
      beats = 1 + int'(rnd(8));
      mem_read_burst(idx, beats);
    end

    // strobed writes, read back
    for (int i = 0; i < 20; i++) begin
      idx   = int'(rnd(npc_axi_pkg::MEM_WORDS));
      beats = 1 + int'(rnd(8));
      mem_write_burst(idx, beats, 1'b1);
      mem_read_burst(idx, beats);
    end

    redirect(npc_core_pkg::pc_t'(rnd(300) * 8));
    run_fetch(100, 1'b1);

    // fetch and data port at the same time
    redirect(npc_core_pkg::pc_t'(rnd(300) * 8 + rnd(2) * 4));
    fork
      run_fetch(120, 1'b1);
      data_traffic(16);
    join

    repeat (2) @(posedge clk);
    $display("mismatches: %0d, timeouts: %0d, instructions checked: %0d",
             mismatches, timeouts, consumed);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+test
hw/npc_axi_pkg.sv
hw/npc_core_pkg.sv
hw/npc_ifu.sv
hw/npc_fetch_queue.sv
hw/npc_arbiter.sv
hw/npc_sram.sv
hw/npc_fetch_top.sv
test/tb_npc_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_npc_fetch -f flist.f -o sim_npc_fetch
out=$(./obj_dir/sim_npc_fetch)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
